/* Makefile */
TOP := hazard_unit_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@! grep -q "test failed" $(LOG)
	@grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/hazard_consts.svh */
`ifndef HAZARD_CONSTS_SVH
`define HAZARD_CONSTS_SVH

// Field widths
`define REG_IDX_W       5
`define CD_CTRL_W       3
`define EXE_CTRL_W      5
`define EXE_SRC_W       3
`define MEM_CTRL_W      4
`define WB_CTRL_W       4

// ID hazard class, 5 and 6 reserved
`define CD_NONE         3'd0
`define CD_BRANCHES     3'd1
`define CD_JALR         3'd2
`define CD_FENCE_I      3'd3
`define CD_EBREAK       3'd4

`define EXE_NOP         5'd0

// EXE operand source
`define EXE_SRC_NOP     3'd0
`define EXE_R_R         3'd1
`define EXE_R_I         3'd2
`define EXE_PC_I        3'd3
`define EXE_R_CSR       3'd4
`define EXE_NOTR_CSR    3'd5
`define EXE_CSR_ZIMM    3'd6
`define EXE_CSR_NOTZIMM 3'd7

`define MEM_NOP         4'd0
`define MEM_LOAD        4'd1
`define MEM_SB          4'd2
`define MEM_SH          4'd3
`define MEM_SW          4'd4
`define MEM_SD          4'd5
`define MEM_FENCE_I     4'd6

// Write-back select
`define WB_NOP          4'd0
`define WB_EXE          4'd1
`define WB_MEM          4'd2
`define WB_IMM          4'd3
`define WB_SNPC         4'd4
`define WB_CSRRW        4'd5
`define WB_CSRRS        4'd6
`define WB_CSRRWI       4'd7
`define WB_ECALL        4'd8

`endif

/* rtl/hazard_pkg.sv */
`include "hazard_consts.svh"

package hazard_pkg;

    typedef logic [`REG_IDX_W-1:0]  reg_idx_t;   // General register number

    typedef logic [`CD_CTRL_W-1:0]  cd_ctrl_t;   // ID hazard class

    typedef logic [`EXE_CTRL_W-1:0] exe_ctrl_t;

    typedef logic [`EXE_SRC_W-1:0]  exe_src_t;   // EXE operand source

    typedef logic [`MEM_CTRL_W-1:0] mem_ctrl_t;

    typedef logic [`WB_CTRL_W-1:0]  wb_ctrl_t;   // Write-back select

endpackage

/* rtl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import hazard_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      id_valid_in,
    input  cd_ctrl_t  cd_ctrl,
    input  reg_idx_t  id_rs1,
    input  reg_idx_t  id_rs2,
    input  logic      exe_valid_in,
    input  exe_ctrl_t exe_ctrl,
    input  exe_src_t  exe_src,
    input  wb_ctrl_t  exe_wb_ctrl,
    input  reg_idx_t  exe_rs1,
    input  reg_idx_t  exe_rs2,
    input  reg_idx_t  exe_rd,
    input  logic      mem_valid_in,
    input  mem_ctrl_t mem_ctrl,
    input  wb_ctrl_t  mem_wb_ctrl,
    input  reg_idx_t  mem_rs2,
    input  reg_idx_t  mem_rd,
    input  logic      wb_valid_in,
    input  wb_ctrl_t  wb_ctrl,
    input  reg_idx_t  wb_rd,
    input  logic      if_flush,
    output logic      if_valid,
    output logic      if_enable,
    output logic      id_valid,
    output logic      id_enable,
    output logic      exe_valid,
    output logic      exe_enable,
    output logic      mem_valid,
    output logic      mem_enable,
    output logic      wb_valid,
    output logic      halted
);

    logic id_conflict;
    logic exe_conflict;
    logic mem_conflict;

    reg_use_if u_use ();

    operand_use_decode u_decode (
        .id_valid_in  (id_valid_in),
        .cd_ctrl      (cd_ctrl),
        .exe_valid_in (exe_valid_in),
        .exe_ctrl     (exe_ctrl),
        .exe_src      (exe_src),
        .exe_wb_ctrl  (exe_wb_ctrl),
        .mem_valid_in (mem_valid_in),
        .mem_ctrl     (mem_ctrl),
        .mem_wb_ctrl  (mem_wb_ctrl),
        .wb_valid_in  (wb_valid_in),
        .wb_ctrl      (wb_ctrl),
        .reg_use      (u_use.decode)
    );

    raw_hazard_detect u_detect (
        .reg_use      (u_use.detect),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .exe_rs1      (exe_rs1),
        .exe_rs2      (exe_rs2),
        .exe_rd       (exe_rd),
        .mem_rs2      (mem_rs2),
        .mem_rd       (mem_rd),
        .wb_rd        (wb_rd),
        .id_conflict  (id_conflict),
        .exe_conflict (exe_conflict),
        .mem_conflict (mem_conflict)
    );

    stall_control u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .id_conflict  (id_conflict),
        .exe_conflict (exe_conflict),
        .mem_conflict (mem_conflict),
        .id_valid_in  (id_valid_in),
        .exe_valid_in (exe_valid_in),
        .mem_valid_in (mem_valid_in),
        .wb_valid_in  (wb_valid_in),
        .if_flush     (if_flush),
        .cd_ctrl      (cd_ctrl),
        .mem_ctrl     (mem_ctrl),
        .if_valid     (if_valid),
        .if_enable    (if_enable),
        .id_valid     (id_valid),
        .id_enable    (id_enable),
        .exe_valid    (exe_valid),
        .exe_enable   (exe_enable),
        .mem_valid    (mem_valid),
        .mem_enable   (mem_enable),
        .wb_valid     (wb_valid),
        .halted       (halted)
    );

endmodule

/* rtl/operand_use_decode.sv */
`timescale 1ns/1ps
`include "hazard_consts.svh"

module operand_use_decode import hazard_pkg::*; (
    input  logic      id_valid_in,
    input  cd_ctrl_t  cd_ctrl,
    input  logic      exe_valid_in,
    input  exe_ctrl_t exe_ctrl,
    input  exe_src_t  exe_src,
    input  wb_ctrl_t  exe_wb_ctrl,
    input  logic      mem_valid_in,
    input  mem_ctrl_t mem_ctrl,
    input  wb_ctrl_t  mem_wb_ctrl,
    input  logic      wb_valid_in,
    input  wb_ctrl_t  wb_ctrl,
    reg_use_if.decode reg_use
);

    logic exe_rs1_read;
    logic exe_rs2_read;
    logic mem_rs2_read;

    // Write-back codes that land in the general register file
    function automatic logic writes_rd(input logic valid, input wb_ctrl_t code);
        logic hit;
        case (code)
            `WB_EXE, `WB_MEM, `WB_IMM, `WB_SNPC,
            `WB_CSRRW, `WB_CSRRS, `WB_CSRRWI: hit = 1'b1;
            default: hit = 1'b0;    // NOP and ecall leave rd alone
        endcase
        return valid & hit;
    endfunction

    assign reg_use.id_rs1_read = id_valid_in &&
                                 (cd_ctrl == `CD_BRANCHES || cd_ctrl == `CD_JALR);
    assign reg_use.id_rs2_read = id_valid_in && (cd_ctrl == `CD_BRANCHES);

    always_comb begin
        exe_rs1_read = 1'b0;
        exe_rs2_read = 1'b0;
        if (exe_valid_in && exe_ctrl != `EXE_NOP) begin
            case (exe_src)
                `EXE_R_R: begin
                    exe_rs1_read = 1'b1;
                    exe_rs2_read = 1'b1;
                end
                `EXE_R_I, `EXE_R_CSR, `EXE_NOTR_CSR: begin
                    exe_rs1_read = 1'b1;
                end
                default: begin
                    exe_rs1_read = 1'b0;    // PC or zimm operands
                end
            endcase
        end
    end

    // Stores read rs2 for the write data
    always_comb begin
        mem_rs2_read = 1'b0;
        if (mem_valid_in) begin
            case (mem_ctrl)
                `MEM_SB, `MEM_SH, `MEM_SW, `MEM_SD: mem_rs2_read = 1'b1;
                default: mem_rs2_read = 1'b0;
            endcase
        end
    end

    assign reg_use.exe_rs1_read = exe_rs1_read;
    assign reg_use.exe_rs2_read = exe_rs2_read;
    assign reg_use.mem_rs2_read = mem_rs2_read;

    assign reg_use.exe_rd_write = writes_rd(exe_valid_in, exe_wb_ctrl);
    assign reg_use.mem_rd_write = writes_rd(mem_valid_in, mem_wb_ctrl);
    assign reg_use.wb_rd_write  = writes_rd(wb_valid_in, wb_ctrl);

endmodule

/* rtl/raw_hazard_detect.sv */
`timescale 1ns/1ps

module raw_hazard_detect import hazard_pkg::*; (
    reg_use_if.detect reg_use,
    input  reg_idx_t  id_rs1,
    input  reg_idx_t  id_rs2,
    input  reg_idx_t  exe_rs1,
    input  reg_idx_t  exe_rs2,
    input  reg_idx_t  exe_rd,
    input  reg_idx_t  mem_rs2,
    input  reg_idx_t  mem_rd,
    input  reg_idx_t  wb_rd,
    output logic      id_conflict,
    output logic      exe_conflict,
    output logic      mem_conflict
);

    logic exe_rd_hit_id_rs1;
    logic exe_rd_hit_id_rs2;
    logic mem_rd_hit_id;
    logic wb_rd_hit_id;
    logic mem_rd_hit_exe;
    logic wb_rd_hit_exe;

    // Destination in flight against each ID source
    assign exe_rd_hit_id_rs1 = reg_use.exe_rd_write && (id_rs1 == exe_rd);
    assign exe_rd_hit_id_rs2 = reg_use.exe_rd_write && (id_rs2 == exe_rd);

    assign mem_rd_hit_id = reg_use.mem_rd_write &&
                           ((reg_use.id_rs1_read && id_rs1 == mem_rd) ||
                            (reg_use.id_rs2_read && id_rs2 == mem_rd));
    assign wb_rd_hit_id  = reg_use.wb_rd_write &&
                           ((reg_use.id_rs1_read && id_rs1 == wb_rd) ||
                            (reg_use.id_rs2_read && id_rs2 == wb_rd));

    assign id_conflict = (reg_use.id_rs1_read && exe_rd_hit_id_rs1) ||
                         (reg_use.id_rs2_read && exe_rd_hit_id_rs2) ||
                         mem_rd_hit_id || wb_rd_hit_id;

    // EXE sources only see MEM and WB
    assign mem_rd_hit_exe = reg_use.mem_rd_write &&
                            ((reg_use.exe_rs1_read && exe_rs1 == mem_rd) ||
                             (reg_use.exe_rs2_read && exe_rs2 == mem_rd));
    assign wb_rd_hit_exe  = reg_use.wb_rd_write &&
                            ((reg_use.exe_rs1_read && exe_rs1 == wb_rd) ||
                             (reg_use.exe_rs2_read && exe_rs2 == wb_rd));

    assign exe_conflict = mem_rd_hit_exe || wb_rd_hit_exe;

    assign mem_conflict = reg_use.mem_rs2_read && reg_use.wb_rd_write &&
                          (mem_rs2 == wb_rd);   // Store data not yet written back

endmodule

/* rtl/reg_use_if.sv */
`timescale 1ns/1ps

interface reg_use_if;

    // Register sources read per stage
    logic id_rs1_read;
    logic id_rs2_read;
    logic exe_rs1_read;
    logic exe_rs2_read;
    logic mem_rs2_read;

    // Destinations written per stage
    logic exe_rd_write;
    logic mem_rd_write;
    logic wb_rd_write;

    modport decode (
        output id_rs1_read, id_rs2_read, exe_rs1_read, exe_rs2_read,
        output mem_rs2_read, exe_rd_write, mem_rd_write, wb_rd_write
    );

    modport detect (
        input id_rs1_read, id_rs2_read, exe_rs1_read, exe_rs2_read,
        input mem_rs2_read, exe_rd_write, mem_rd_write, wb_rd_write
    );

endinterface

/* rtl/stall_control.sv */
`timescale 1ns/1ps
`include "hazard_consts.svh"

module stall_control import hazard_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      id_conflict,
    input  logic      exe_conflict,
    input  logic      mem_conflict,
    input  logic      id_valid_in,
    input  logic      exe_valid_in,
    input  logic      mem_valid_in,
    input  logic      wb_valid_in,
    input  logic      if_flush,
    input  cd_ctrl_t  cd_ctrl,
    input  mem_ctrl_t mem_ctrl,
    output logic      if_valid,
    output logic      if_enable,
    output logic      id_valid,
    output logic      id_enable,
    output logic      exe_valid,
    output logic      exe_enable,
    output logic      mem_valid,
    output logic      mem_enable,
    output logic      wb_valid,
    output logic      halted
);

    logic ebreak_id;
    logic fence_wait;
    logic any_conflict;
    logic pipe_empty;

    assign ebreak_id    = id_valid_in && (cd_ctrl == `CD_EBREAK);
    // fence.i holds fetch until its MEM pass, regardless of ID valid
    assign fence_wait   = (cd_ctrl == `CD_FENCE_I) && (mem_ctrl != `MEM_FENCE_I);
    assign any_conflict = id_conflict || exe_conflict || mem_conflict;
    assign pipe_empty   = !exe_valid_in && !mem_valid_in && !wb_valid_in;

    assign if_valid   = !(id_conflict || ebreak_id || fence_wait);
    assign if_enable  = !any_conflict;
    assign id_valid   = !(id_valid_in && if_flush);     // Taken branch kills ID
    assign id_enable  = !(any_conflict || ebreak_id);
    assign exe_valid  = !(id_conflict || ebreak_id);    // Bubble into EXE
    assign exe_enable = !(exe_conflict || mem_conflict);
    assign mem_valid  = !exe_conflict;
    assign mem_enable = !mem_conflict;
    assign wb_valid   = !mem_conflict;

    // Sticky once ebreak reaches ID with the rest of the pipe drained
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (ebreak_id && pipe_empty) begin
            halted <= 1'b1;
        end
    end

endmodule

/* src.f */
+incdir+rtl
rtl/hazard_pkg.sv
rtl/reg_use_if.sv
rtl/operand_use_decode.sv
rtl/raw_hazard_detect.sv
rtl/stall_control.sv
rtl/hazard_unit.sv
testbench/hazard_unit_asserts.sv
testbench/hazard_unit_tb.sv

/* testbench/hazard_unit_asserts.sv */
`timescale 1ns/1ps
`include "hazard_consts.svh"

module hazard_unit_asserts import hazard_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     id_valid_in,
    input cd_ctrl_t cd_ctrl,
    input logic     exe_valid_in,
    input logic     mem_valid_in,
    input logic     wb_valid_in,
    input logic     if_enable,
    input logic     mem_enable,
    input logic     wb_valid,
    input logic     halted
);

    // Sticky until reset
    assert property (@(posedge clk) $fell(halted) |-> $past(reset))
        else $error("halted cleared without reset");

    assert property (@(posedge clk) wb_valid == mem_enable)
        else $error("wb_valid differs from mem_enable");

    assert property (@(posedge clk) !mem_enable |-> !if_enable)
        else $error("store conflict without fetch stall");

    assert property (@(posedge clk) $rose(halted) |->
                     $past(id_valid_in && cd_ctrl == `CD_EBREAK &&
                           !exe_valid_in && !mem_valid_in && !wb_valid_in))
        else $error("halted set without drained ebreak");

endmodule

/* testbench/hazard_unit_tb.sv */
`timescale 1ns/1ps
`include "hazard_consts.svh"

module hazard_unit_tb import hazard_pkg::*;;

    localparam int NUM_CYCLES = 4000;

    logic      clk = 1'b0;
    logic      reset;
    logic      id_valid_in, exe_valid_in, mem_valid_in, wb_valid_in, if_flush;
    cd_ctrl_t  cd_ctrl;
    exe_ctrl_t exe_ctrl;
    exe_src_t  exe_src;
    mem_ctrl_t mem_ctrl;
    wb_ctrl_t  exe_wb_ctrl, mem_wb_ctrl, wb_ctrl;
    reg_idx_t  id_rs1, id_rs2, exe_rs1, exe_rs2, exe_rd, mem_rs2, mem_rd, wb_rd;
    logic      if_valid, if_enable, id_valid, id_enable, exe_valid;
    logic      exe_enable, mem_valid, mem_enable, wb_valid, halted;

    integer seed = 70270;
    int     errors = 0;
    int     checks = 0;
    logic   exp_halted = 1'b0;
    logic   halt_set = 1'b0;    // Model of the halt condition in the current cycle

    hazard_unit dut0 (.*);

    bind hazard_unit hazard_unit_asserts u_asserts (.*);

    always #5 clk = ~clk;

    // Reference for the sticky halt flag
    always @(posedge clk) begin
        if (reset) begin
            exp_halted <= 1'b0;
        end else if (halt_set) begin
            exp_halted <= 1'b1;
        end
    end

    function automatic logic writes_reg(input logic valid, input wb_ctrl_t sel);
        return valid && (sel inside {`WB_EXE, `WB_MEM, `WB_IMM, `WB_SNPC,
                                     `WB_CSRRW, `WB_CSRRS, `WB_CSRRWI});
    endfunction

    function automatic logic hits_dest(input reg_idx_t src, input logic exe_w,
                                       input logic mem_w, input logic wb_w);
        return (exe_w && src == exe_rd) || (mem_w && src == mem_rd) ||
               (wb_w && src == wb_rd);
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic model_and_check();
        logic id_r1, id_r2, ex_r1, ex_r2, mem_r2, ex_w, mem_w, wb_w;
        logic id_c, ex_c, mem_c, ebreak, fence_wait;
        id_r1  = id_valid_in && (cd_ctrl == `CD_BRANCHES || cd_ctrl == `CD_JALR);
        id_r2  = id_valid_in && cd_ctrl == `CD_BRANCHES;
        ex_r1  = exe_valid_in && exe_ctrl != `EXE_NOP &&
                 (exe_src inside {`EXE_R_R, `EXE_R_I, `EXE_R_CSR, `EXE_NOTR_CSR});
        ex_r2  = exe_valid_in && exe_ctrl != `EXE_NOP && exe_src == `EXE_R_R;
        mem_r2 = mem_valid_in && (mem_ctrl inside {`MEM_SB, `MEM_SH, `MEM_SW, `MEM_SD});
        ex_w   = writes_reg(exe_valid_in, exe_wb_ctrl);
        mem_w  = writes_reg(mem_valid_in, mem_wb_ctrl);
        wb_w   = writes_reg(wb_valid_in, wb_ctrl);
        id_c   = (id_r1 && hits_dest(id_rs1, ex_w, mem_w, wb_w)) ||
                 (id_r2 && hits_dest(id_rs2, ex_w, mem_w, wb_w));
        ex_c   = (ex_r1 && hits_dest(exe_rs1, 1'b0, mem_w, wb_w)) ||
                 (ex_r2 && hits_dest(exe_rs2, 1'b0, mem_w, wb_w));
        mem_c  = mem_r2 && wb_w && mem_rs2 == wb_rd;
        ebreak = id_valid_in && cd_ctrl == `CD_EBREAK;
        fence_wait = cd_ctrl == `CD_FENCE_I && mem_ctrl != `MEM_FENCE_I;
        halt_set = ebreak && !exe_valid_in && !mem_valid_in && !wb_valid_in;
        check_bit("if_valid", !(id_c || ebreak || fence_wait), if_valid);
        check_bit("if_enable", !(id_c || ex_c || mem_c), if_enable);
        check_bit("id_valid", !(id_valid_in && if_flush), id_valid);
        check_bit("id_enable", !(id_c || ex_c || mem_c || ebreak), id_enable);
        check_bit("exe_valid", !(id_c || ebreak), exe_valid);
        check_bit("exe_enable", !(ex_c || mem_c), exe_enable);
        check_bit("mem_valid", !ex_c, mem_valid);
        check_bit("mem_enable", !mem_c, mem_enable);
        check_bit("wb_valid", !mem_c, wb_valid);
        check_bit("halted", exp_halted, halted);
    endtask

    // Outputs settle between edges
    always @(negedge clk) model_and_check();

    task automatic drive_random();
        logic [31:0] r;
        r = $random(seed);
        if (r[4:0] == 5'd0) cd_ctrl <= `CD_EBREAK;     // Rare
        else cd_ctrl <= cd_ctrl_t'(r[6:5]);
        id_valid_in <= r[7];
        if_flush    <= r[8] && r[9];
        id_rs1      <= reg_idx_t'(r[11:10]);
        id_rs2      <= reg_idx_t'(r[13:12]);
        r = $random(seed);
        exe_valid_in <= r[0];
        exe_ctrl     <= (r[2:1] == 2'd0) ? `EXE_NOP : exe_ctrl_t'(r[7:3]);
        exe_src      <= r[10:8];
        exe_wb_ctrl  <= r[14:11] % 4'd10;   // Includes an unused code
        exe_rs1      <= reg_idx_t'(r[16:15]);
        exe_rs2      <= reg_idx_t'(r[18:17]);
        exe_rd       <= reg_idx_t'(r[20:19]);
        r = $random(seed);
        mem_valid_in <= r[0];
        mem_ctrl     <= mem_ctrl_t'(r[3:1]);
        mem_wb_ctrl  <= r[7:4] % 4'd10;
        mem_rs2      <= reg_idx_t'(r[9:8]);
        mem_rd       <= reg_idx_t'(r[11:10]);
        wb_valid_in  <= r[12];
        wb_ctrl      <= r[16:13] % 4'd10;
        wb_rd        <= reg_idx_t'(r[18:17]);
    endtask

    task automatic random_cycles(input int n, input logic rst);
        repeat (n) begin
            @(posedge clk);
            reset <= rst;
            drive_random();
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("test failed");
        $finish;
    endtask

    task automatic release_reset();
        int cnt;
        cnt = 0;
        @(posedge clk);
        reset <= 1'b0;
        while (reset !== 1'b0) begin
            if (cnt >= 4) abort_on_timeout("reset to be released");
            else begin
                @(posedge clk);
                cnt++;
            end
        end
    endtask

    // ebreak in ID with EXE, MEM and WB empty
    task automatic force_halt();
        int cnt;
        cnt = 0;
        @(posedge clk);
        id_valid_in  <= 1'b1;
        cd_ctrl      <= `CD_EBREAK;
        exe_valid_in <= 1'b0;
        mem_valid_in <= 1'b0;
        wb_valid_in  <= 1'b0;
        while (halted !== 1'b1) begin
            if (cnt >= 5) abort_on_timeout("halted to set after ebreak");
            else begin
                @(posedge clk);
                cnt++;
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        {id_valid_in, exe_valid_in, mem_valid_in, wb_valid_in, if_flush} = '0;
        cd_ctrl = `CD_NONE;
        exe_ctrl = `EXE_NOP;
        exe_src = `EXE_SRC_NOP;
        mem_ctrl = `MEM_NOP;
        {exe_wb_ctrl, mem_wb_ctrl, wb_ctrl} = '0;
        {id_rs1, id_rs2, exe_rs1, exe_rs2, exe_rd, mem_rs2, mem_rd, wb_rd} = '0;
        random_cycles(8, 1'b1);
        release_reset();
        random_cycles(NUM_CYCLES / 2, 1'b0);
        force_halt();
        random_cycles(8, 1'b1);     // Second reset clears halted
        release_reset();
        random_cycles(NUM_CYCLES / 2, 1'b0);
        @(posedge clk);     // Last negedge check has finished by now
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
